// ==== rtl/rv_pkg.sv ====
package rv_pkg;

    localparam int XLEN = 64;

    typedef logic [XLEN-1:0] data_t;
    typedef logic [XLEN-1:0] addr_t;
    typedef logic [31:0]     inst_t;
    typedef logic [4:0]      reg_idx_t;

    // major opcodes that the core executes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    // ALU_ADD is zero so that an all-zero ctrl is a no-op
    typedef enum logic [2:0] {
        ALU_ADD  = 3'd0,
        ALU_SUB  = 3'd1,
        ALU_AND  = 3'd2,
        ALU_OR   = 3'd3,
        ALU_XOR  = 3'd4,
        ALU_SLT  = 3'd5,
        ALU_SLTU = 3'd6
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE = 3'd0,
        BR_EQ   = 3'd1,
        BR_NE   = 3'd2,
        BR_LT   = 3'd3,
        BR_GE   = 3'd4
    } branch_e;

    typedef struct packed {
        alu_op_e alu_op;
        logic    src_imm;
        logic    rd_en;
        logic    is_lui;
        logic    is_load;
        logic    is_store;
        logic    is_jal;
        branch_e branch;
    } ctrl_t;

    // instruction bus
    typedef struct packed {
        logic  valid;
        addr_t addr;
    } if_req_t;

    typedef struct packed {
        logic  ready;
        inst_t data;
    } if_rsp_t;

    // data bus, doubleword accesses only
    typedef struct packed {
        logic  valid;
        logic  write;
        addr_t addr;
        data_t wdata;
    } dmem_req_t;

    typedef struct packed {
        logic  ready;
        data_t rdata;
    } dmem_rsp_t;

endpackage

// ==== rtl/fetch_unit.sv ====
`timescale 1ns/1ns

module fetch_unit #(
    parameter rv_pkg::addr_t pc_start = 64'h0000_0000_8000_0000
) (
    input  logic            inst_selfdefine,
    input  logic            reset,
    input  rv_pkg::if_rsp_t if_rsp,
    input  logic            stall,
    input  logic            take_branch,
    input  rv_pkg::addr_t   target,
    output rv_pkg::if_req_t if_req,
    output rv_pkg::addr_t   pc,
    output rv_pkg::inst_t   inst,
    output logic            exec,
    output logic            commit
);

    typedef enum logic {
        S_FETCH,
        S_EXEC
    } state_e;

    state_e        state_q;
    logic          req_q;
    logic          fetch_hs;
    rv_pkg::addr_t pc_q;
    rv_pkg::inst_t inst_q;

    assign fetch_hs = req_q & if_rsp.ready;
    assign exec     = (state_q == S_EXEC);
    assign commit   = exec & ~stall;

    assign if_req.valid = req_q;
    assign if_req.addr  = pc_q;
    assign pc           = pc_q;
    assign inst         = inst_q;

    // req_q is low in FETCH only during the first cycle out of reset
    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            state_q <= S_FETCH;
            req_q   <= 1'b0;
            pc_q    <= pc_start;
        end else begin
            case (state_q)
                S_FETCH: begin
                    if (fetch_hs) begin
                        state_q <= S_EXEC;
                        req_q   <= 1'b0;
                    end else begin
                        req_q   <= 1'b1;
                    end
                end
                S_EXEC: begin
                    if (!stall) begin
                        state_q <= S_FETCH;
                        req_q   <= 1'b1;
                        pc_q    <= take_branch ? target : pc_q + 64'd4;
                    end
                end
                default: begin
                    state_q <= S_FETCH;
                end
            endcase
        end
    end

    // instruction word is held for the whole EXEC phase
    always_ff @(posedge inst_selfdefine) begin
        if (fetch_hs) begin
            inst_q <= if_rsp.data;
        end
    end

    // a pending fetch keeps its address until accepted
    addr_hold: assert property (
        @(posedge inst_selfdefine) disable iff (reset)
        if_req.valid && !if_rsp.ready |=> if_req.valid && $stable(if_req.addr)
    );

endmodule

// ==== rtl/decoder.sv ====
`timescale 1ns/1ns

module decoder (
    input  rv_pkg::inst_t    inst,
    output rv_pkg::reg_idx_t rs1_idx,
    output rv_pkg::reg_idx_t rs2_idx,
    output rv_pkg::reg_idx_t rd_idx,
    output rv_pkg::data_t    imm,
    output rv_pkg::ctrl_t    ctrl
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode  = inst[6:0];
    assign funct3  = inst[14:12];
    assign funct7  = inst[31:25];
    assign rs1_idx = inst[19:15];
    assign rs2_idx = inst[24:20];
    assign rd_idx  = inst[11:7];

    // immediate format follows the opcode
    always_comb begin
        case (opcode)
            rv_pkg::OPC_OP_IMM,
            rv_pkg::OPC_LOAD:   imm = {{52{inst[31]}}, inst[31:20]};
            rv_pkg::OPC_STORE:  imm = {{52{inst[31]}}, inst[31:25], inst[11:7]};
            rv_pkg::OPC_BRANCH: imm = {{52{inst[31]}}, inst[7], inst[30:25],
                                       inst[11:8], 1'b0};
            rv_pkg::OPC_LUI:    imm = {{32{inst[31]}}, inst[31:12], 12'b0};
            rv_pkg::OPC_JAL:    imm = {{44{inst[31]}}, inst[19:12], inst[20],
                                       inst[30:21], 1'b0};
            default:            imm = '0;
        endcase
    end

    always_comb begin
        ctrl = '0;
        case (opcode)
            rv_pkg::OPC_OP,
            rv_pkg::OPC_OP_IMM: begin
                ctrl.rd_en   = 1'b1;
                ctrl.src_imm = (opcode == rv_pkg::OPC_OP_IMM);
                case (funct3)
                    3'b000: begin
                        if (opcode == rv_pkg::OPC_OP && funct7[5]) begin
                            ctrl.alu_op = rv_pkg::ALU_SUB;
                        end else begin
                            ctrl.alu_op = rv_pkg::ALU_ADD;
                        end
                    end
                    3'b010:  ctrl.alu_op = rv_pkg::ALU_SLT;
                    3'b011:  ctrl.alu_op = rv_pkg::ALU_SLTU;
                    3'b100:  ctrl.alu_op = rv_pkg::ALU_XOR;
                    3'b110:  ctrl.alu_op = rv_pkg::ALU_OR;
                    3'b111:  ctrl.alu_op = rv_pkg::ALU_AND;
                    // shifts are not executed
                    default: ctrl = '0;
                endcase
            end
            rv_pkg::OPC_LUI: begin
                ctrl.rd_en  = 1'b1;
                ctrl.is_lui = 1'b1;
            end
            rv_pkg::OPC_LOAD: begin
                if (funct3 == 3'b011) begin
                    ctrl.src_imm = 1'b1;
                    ctrl.rd_en   = 1'b1;
                    ctrl.is_load = 1'b1;
                end
            end
            rv_pkg::OPC_STORE: begin
                if (funct3 == 3'b011) begin
                    ctrl.src_imm  = 1'b1;
                    ctrl.is_store = 1'b1;
                end
            end
            rv_pkg::OPC_BRANCH: begin
                case (funct3)
                    3'b000:  ctrl.branch = rv_pkg::BR_EQ;
                    3'b001:  ctrl.branch = rv_pkg::BR_NE;
                    3'b100:  ctrl.branch = rv_pkg::BR_LT;
                    3'b101:  ctrl.branch = rv_pkg::BR_GE;
                    default: ctrl.branch = rv_pkg::BR_NONE;
                endcase
            end
            rv_pkg::OPC_JAL: begin
                ctrl.rd_en  = 1'b1;
                ctrl.is_jal = 1'b1;
            end
            default: ctrl = '0;
        endcase
    end

endmodule

// ==== rtl/execute.sv ====
`timescale 1ns/1ns

module execute (
    input  rv_pkg::addr_t pc,
    input  rv_pkg::data_t rs1_data,
    input  rv_pkg::data_t rs2_data,
    input  rv_pkg::data_t imm,
    input  rv_pkg::ctrl_t ctrl,
    output rv_pkg::data_t alu_res,
    output rv_pkg::data_t ex_res,
    output logic          take_branch,
    output rv_pkg::addr_t target
);

    rv_pkg::data_t op_b;
    logic          eq;
    logic          lt_s;
    logic          lt_u;
    logic          cond;

    // branches decode with src_imm low, so op_b is rs2 there
    assign op_b = ctrl.src_imm ? imm : rs2_data;

    // one comparator for slt/sltu and the branch conditions
    assign eq   = (rs1_data == op_b);
    assign lt_s = ($signed(rs1_data) < $signed(op_b));
    assign lt_u = (rs1_data < op_b);

    always_comb begin
        case (ctrl.alu_op)
            rv_pkg::ALU_ADD:  alu_res = rs1_data + op_b;
            rv_pkg::ALU_SUB:  alu_res = rs1_data - op_b;
            rv_pkg::ALU_AND:  alu_res = rs1_data & op_b;
            rv_pkg::ALU_OR:   alu_res = rs1_data | op_b;
            rv_pkg::ALU_XOR:  alu_res = rs1_data ^ op_b;
            rv_pkg::ALU_SLT:  alu_res = {63'b0, lt_s};
            rv_pkg::ALU_SLTU: alu_res = {63'b0, lt_u};
            default:          alu_res = rs1_data + op_b;
        endcase
    end

    always_comb begin
        case (ctrl.branch)
            rv_pkg::BR_EQ: cond = eq;
            rv_pkg::BR_NE: cond = ~eq;
            rv_pkg::BR_LT: cond = lt_s;
            rv_pkg::BR_GE: cond = ~lt_s;
            default:       cond = 1'b0;
        endcase
    end

    assign take_branch = ctrl.is_jal | cond;
    assign target      = pc + imm;

    // link value for jal, upper immediate for lui
    assign ex_res = ctrl.is_jal ? pc + 64'd4 :
                    ctrl.is_lui ? imm : alu_res;

endmodule

// ==== rtl/regfile.sv ====
`timescale 1ns/1ns

module regfile (
    input  logic             inst_selfdefine,
    input  logic             reset,
    input  rv_pkg::reg_idx_t rs1_idx,
    input  rv_pkg::reg_idx_t rs2_idx,
    input  rv_pkg::reg_idx_t rd_idx,
    input  logic             rd_en,
    input  rv_pkg::data_t    wb_data,
    output rv_pkg::data_t    rs1_data,
    output rv_pkg::data_t    rs2_data
);

    rv_pkg::data_t regs [32];

    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_en && rd_idx != 5'd0) begin
            regs[rd_idx] <= wb_data;
        end
    end

    // x0 is cleared by reset and never written
    assign rs1_data = regs[rs1_idx];
    assign rs2_data = regs[rs2_idx];

    x0_zero: assert property (
        @(posedge inst_selfdefine) disable iff (reset)
        rd_en && rd_idx == 5'd0 |=> regs[0] == '0
    );

endmodule

// ==== rtl/mem_access.sv ====
`timescale 1ns/1ns

module mem_access (
    input  logic              inst_selfdefine,
    input  logic              reset,
    input  logic              exec,
    input  rv_pkg::ctrl_t     ctrl,
    input  rv_pkg::data_t     alu_res,
    input  rv_pkg::data_t     rs2_data,
    input  rv_pkg::data_t     ex_res,
    input  rv_pkg::dmem_rsp_t dmem_rsp,
    output rv_pkg::dmem_req_t dmem_req,
    output logic              stall,
    output rv_pkg::data_t     wb_data
);

    logic mem_op;

    assign mem_op = ctrl.is_load | ctrl.is_store;

    // request lives for the whole EXEC phase of a load or store
    assign dmem_req.valid = exec & mem_op;
    assign dmem_req.write = ctrl.is_store;
    assign dmem_req.addr  = alu_res;
    assign dmem_req.wdata = rs2_data;

    // hold the core in EXEC until the handshake
    assign stall = dmem_req.valid & ~dmem_rsp.ready;

    // rdata is valid in the ready cycle, which is also the commit cycle
    assign wb_data = ctrl.is_load ? dmem_rsp.rdata : ex_res;

    no_req_in_reset: assert property (
        @(posedge inst_selfdefine)
        reset |=> !dmem_req.valid
    );

    // the latched instruction and register operands keep the request stable
    req_hold: assert property (
        @(posedge inst_selfdefine) disable iff (reset)
        dmem_req.valid && !dmem_rsp.ready |=>
            dmem_req.valid && $stable(dmem_req.write) &&
            $stable(dmem_req.addr) && $stable(dmem_req.wdata)
    );

endmodule

// ==== rtl/cpu.sv ====
`timescale 1ns/1ns

module cpu #(
    parameter rv_pkg::addr_t pc_start = 64'h0000_0000_8000_0000
) (
    input  logic              inst_selfdefine,
    input  logic              reset,
    output rv_pkg::if_req_t   if_req,
    input  rv_pkg::if_rsp_t   if_rsp,
    output rv_pkg::dmem_req_t dmem_req,
    input  rv_pkg::dmem_rsp_t dmem_rsp
);

    rv_pkg::addr_t    pc;
    rv_pkg::inst_t    inst;
    logic             exec;
    logic             commit;
    logic             stall;
    logic             take_branch;
    rv_pkg::addr_t    target;

    rv_pkg::reg_idx_t rs1_idx;
    rv_pkg::reg_idx_t rs2_idx;
    rv_pkg::reg_idx_t rd_idx;
    rv_pkg::data_t    imm;
    rv_pkg::ctrl_t    ctrl;

    rv_pkg::data_t    rs1_data;
    rv_pkg::data_t    rs2_data;
    rv_pkg::data_t    alu_res;
    rv_pkg::data_t    ex_res;
    rv_pkg::data_t    wb_data;

    fetch_unit #(
        .pc_start(pc_start)
    ) fetch_unit_i (
        .inst_selfdefine(inst_selfdefine),
        .reset          (reset),
        .if_rsp         (if_rsp),
        .stall          (stall),
        .take_branch    (take_branch),
        .target         (target),
        .if_req         (if_req),
        .pc             (pc),
        .inst           (inst),
        .exec           (exec),
        .commit         (commit)
    );

    decoder decoder_i (
        .inst   (inst),
        .rs1_idx(rs1_idx),
        .rs2_idx(rs2_idx),
        .rd_idx (rd_idx),
        .imm    (imm),
        .ctrl   (ctrl)
    );

    // write back only on the commit edge
    regfile regfile_i (
        .inst_selfdefine(inst_selfdefine),
        .reset          (reset),
        .rs1_idx        (rs1_idx),
        .rs2_idx        (rs2_idx),
        .rd_idx         (rd_idx),
        .rd_en          (commit & ctrl.rd_en),
        .wb_data        (wb_data),
        .rs1_data       (rs1_data),
        .rs2_data       (rs2_data)
    );

    execute execute_i (
        .pc         (pc),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .imm        (imm),
        .ctrl       (ctrl),
        .alu_res    (alu_res),
        .ex_res     (ex_res),
        .take_branch(take_branch),
        .target     (target)
    );

    mem_access mem_access_i (
        .inst_selfdefine(inst_selfdefine),
        .reset          (reset),
        .exec           (exec),
        .ctrl           (ctrl),
        .alu_res        (alu_res),
        .rs2_data       (rs2_data),
        .ex_res         (ex_res),
        .dmem_rsp       (dmem_rsp),
        .dmem_req       (dmem_req),
        .stall          (stall),
        .wb_data        (wb_data)
    );

endmodule

// ==== testbench/tb_cpu.sv ====
`timescale 1ns/1ns

module tb_cpu;

    localparam rv_pkg::addr_t PC_START = 64'h0000_0000_8000_0000;
    localparam int PROG_LEN = 50;
    localparam int MEM_DEPTH = 64;
    localparam int TIMEOUT = PROG_LEN * 12;

    logic              inst_selfdefine;
    logic              reset;
    rv_pkg::if_req_t   if_req;
    rv_pkg::if_rsp_t   if_rsp;
    rv_pkg::dmem_req_t dmem_req;
    rv_pkg::dmem_rsp_t dmem_rsp;

    rv_pkg::inst_t imem [PROG_LEN];
    rv_pkg::data_t dmem [MEM_DEPTH];
    rv_pkg::data_t ref_mem [MEM_DEPTH];
    rv_pkg::data_t ref_regs [32];
    rv_pkg::addr_t ref_pc;
    rv_pkg::dmem_req_t exp_req;
    logic          exp_pending;
    logic          done;
    int            n_inst;
    int            cycles;
    int            val_errors;
    int            proto_errors;
    logic [15:0]   lfsr;

    rv_pkg::if_req_t   last_if_req;
    rv_pkg::dmem_req_t last_dm_req;
    logic              if_waiting;
    logic              dm_waiting;

    cpu #(
        .pc_start(PC_START)
    ) cpu_i (
        .inst_selfdefine(inst_selfdefine),
        .reset          (reset),
        .if_req         (if_req),
        .if_rsp         (if_rsp),
        .dmem_req       (dmem_req),
        .dmem_rsp       (dmem_rsp)
    );

    initial begin
        inst_selfdefine = 1'b0;
        forever #50 inst_selfdefine = ~inst_selfdefine;
    end

    always @(posedge inst_selfdefine) begin
        if (!reset) begin
            cycles <= cycles + 1;
        end
    end

    // galois lfsr stepped once per bit
    function automatic logic lfsr_bit();
        logic lsb;
        lsb = lfsr[0];
        lfsr = lfsr >> 1;
        if (lsb) begin
            lfsr = lfsr ^ 16'hB400;
        end
        return lsb;
    endfunction

    function automatic logic [1:0] rand_delay();
        logic [1:0] d;
        d[0] = lfsr_bit();
        d[1] = lfsr_bit();
        return d;
    endfunction

    function automatic rv_pkg::data_t fill_word(input rv_pkg::addr_t a);
        return 64'h0123_4567_89ab_cdef ^ (a * 64'h9e37_79b9_7f4a_7c15);
    endfunction

    // instruction encoders
    function automatic rv_pkg::inst_t enc_r(input int f7, input int rs2, input int rs1,
                                            input int f3, input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], rv_pkg::OPC_OP};
    endfunction

    function automatic rv_pkg::inst_t enc_i(input int imm, input int rs1, input int f3,
                                            input int rd, input logic [6:0] opc);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
    endfunction

    function automatic rv_pkg::inst_t enc_s(input int imm, input int rs2, input int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b011, imm[4:0], rv_pkg::OPC_STORE};
    endfunction

    function automatic rv_pkg::inst_t enc_b(input int off, input int rs2, input int rs1,
                                            input int f3);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11],
                rv_pkg::OPC_BRANCH};
    endfunction

    function automatic rv_pkg::inst_t enc_j(input int off, input int rd);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], rv_pkg::OPC_JAL};
    endfunction

    task automatic put(input rv_pkg::inst_t w);
        imem[n_inst[5:0]] = w;
        n_inst = n_inst + 1;
    endtask

    function automatic rv_pkg::inst_t inst_at(input rv_pkg::addr_t a);
        rv_pkg::addr_t off;
        off = a - PC_START;
        if (off < 64'(4 * PROG_LEN)) begin
            return imem[off[7:2]];
        end
        return 32'h0000_0013;
    endfunction

    // runs one instruction on the reference state and returns the expected data request
    function automatic rv_pkg::dmem_req_t ref_step(input rv_pkg::inst_t w,
                                                   output rv_pkg::addr_t next_pc);
        rv_pkg::dmem_req_t req;
        rv_pkg::data_t     a;
        rv_pkg::data_t     b;
        rv_pkg::data_t     r;
        rv_pkg::data_t     imm_i;
        rv_pkg::data_t     imm_s;
        rv_pkg::data_t     imm_b;
        rv_pkg::data_t     imm_j;
        logic              wr;
        logic              taken;
        req = '0;
        r = '0;
        wr = 1'b0;
        taken = 1'b0;
        a = ref_regs[w[19:15]];
        b = ref_regs[w[24:20]];
        imm_i = {{52{w[31]}}, w[31:20]};
        imm_s = {{52{w[31]}}, w[31:25], w[11:7]};
        imm_b = {{52{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        imm_j = {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        next_pc = ref_pc + 64'd4;
        case (w[6:0])
            rv_pkg::OPC_OP, rv_pkg::OPC_OP_IMM: begin
                if (w[6:0] == rv_pkg::OPC_OP_IMM) begin
                    b = imm_i;
                end
                wr = 1'b1;
                case (w[14:12])
                    3'b000:  r = (w[6:0] == rv_pkg::OPC_OP && w[30]) ? a - b : a + b;
                    3'b010:  r = {63'd0, $signed(a) < $signed(b)};
                    3'b011:  r = {63'd0, a < b};
                    3'b100:  r = a ^ b;
                    3'b110:  r = a | b;
                    3'b111:  r = a & b;
                    default: wr = 1'b0;
                endcase
            end
            rv_pkg::OPC_LUI: begin
                r = {{32{w[31]}}, w[31:12], 12'd0};
                wr = 1'b1;
            end
            rv_pkg::OPC_LOAD: begin
                if (w[14:12] == 3'b011) begin
                    req.valid = 1'b1;
                    req.addr = a + imm_i;
                    r = ref_mem[req.addr[8:3]];
                    wr = 1'b1;
                end
            end
            rv_pkg::OPC_STORE: begin
                if (w[14:12] == 3'b011) begin
                    req.valid = 1'b1;
                    req.write = 1'b1;
                    req.addr = a + imm_s;
                    req.wdata = b;
                    ref_mem[req.addr[8:3]] = b;
                end
            end
            rv_pkg::OPC_BRANCH: begin
                case (w[14:12])
                    3'b000:  taken = (a == b);
                    3'b001:  taken = (a != b);
                    3'b100:  taken = ($signed(a) < $signed(b));
                    3'b101:  taken = !($signed(a) < $signed(b));
                    default: taken = 1'b0;
                endcase
                if (taken) begin
                    next_pc = ref_pc + imm_b;
                end
            end
            rv_pkg::OPC_JAL: begin
                r = ref_pc + 64'd4;
                wr = 1'b1;
                next_pc = ref_pc + imm_j;
            end
            default: wr = 1'b0;
        endcase
        if (wr && w[11:7] != 5'd0) begin
            ref_regs[w[11:7]] = r;
        end
        return req;
    endfunction

    task automatic check_fetch(input rv_pkg::addr_t addr);
        if (addr !== ref_pc) begin
            val_errors++;
            $display("[FAIL] %0t ns: fetch address %h, expected %h", $time, addr, ref_pc);
        end
    endtask

    task automatic check_store(input rv_pkg::dmem_req_t req);
        if (req.write !== exp_req.write || req.addr !== exp_req.addr ||
            (exp_req.write && req.wdata !== exp_req.wdata)) begin
            val_errors++;
            $display("[FAIL] %0t ns: data req w=%b addr=%h wdata=%h, exp w=%b addr=%h wdata=%h",
                     $time, req.write, req.addr, req.wdata,
                     exp_req.write, exp_req.addr, exp_req.wdata);
        end
    endtask

    // bus models drive their responses just after the rising edge
    initial begin
        logic              i_armed;
        logic              d_armed;
        logic              i_accept;
        logic              d_accept;
        logic [1:0]        i_wait;
        logic [1:0]        d_wait;
        rv_pkg::dmem_req_t d_acc_req;
        if_rsp = '0;
        dmem_rsp = '0;
        i_armed = 1'b0;
        d_armed = 1'b0;
        i_accept = 1'b0;
        d_accept = 1'b0;
        i_wait = 2'd0;
        d_wait = 2'd0;
        d_acc_req = '0;
        forever begin
            @(posedge inst_selfdefine);
            #1;
            if (reset) begin
                if_rsp.ready = 1'b0;
                dmem_rsp.ready = 1'b0;
                i_armed = 1'b0;
                d_armed = 1'b0;
                i_accept = 1'b0;
                d_accept = 1'b0;
            end else begin
                if (i_accept) begin
                    i_armed = 1'b0;
                    i_accept = 1'b0;
                end
                if (d_accept) begin
                    if (d_acc_req.write) begin
                        dmem[d_acc_req.addr[8:3]] = d_acc_req.wdata;
                    end
                    d_armed = 1'b0;
                    d_accept = 1'b0;
                end
                if_rsp.ready = 1'b0;
                if (if_req.valid) begin
                    if (!i_armed) begin
                        i_wait = rand_delay();
                        i_armed = 1'b1;
                    end
                    if (i_wait == 2'd0) begin
                        if_rsp.ready = 1'b1;
                        if_rsp.data = inst_at(if_req.addr);
                        i_accept = 1'b1;
                    end else begin
                        i_wait = i_wait - 2'd1;
                    end
                end
                dmem_rsp.ready = 1'b0;
                if (dmem_req.valid) begin
                    if (!d_armed) begin
                        d_wait = rand_delay();
                        d_armed = 1'b1;
                    end
                    if (d_wait == 2'd0) begin
                        dmem_rsp.ready = 1'b1;
                        dmem_rsp.rdata = dmem[dmem_req.addr[8:3]];
                        d_acc_req = dmem_req;
                        d_accept = 1'b1;
                    end else begin
                        d_wait = d_wait - 2'd1;
                    end
                end
            end
        end
    end

    // compare at the falling edge when every signal has settled
    always @(negedge inst_selfdefine) begin
        rv_pkg::addr_t next_pc;
        if (reset) begin
            if (dmem_req.valid || if_req.valid) begin
                proto_errors++;
                $display("%0t ns: a bus request was raised during reset", $time);
            end
        end else if (!done) begin
            if (if_waiting && (!if_req.valid || if_req.addr !== last_if_req.addr)) begin
                proto_errors++;
                $display("%0t ns: fetch request changed before it was accepted", $time);
            end
            if (dm_waiting && (!dmem_req.valid || dmem_req !== last_dm_req)) begin
                proto_errors++;
                $display("%0t ns: data request changed before it was accepted", $time);
            end
            if_waiting = if_req.valid && !if_rsp.ready;
            dm_waiting = dmem_req.valid && !dmem_rsp.ready;
            last_if_req = if_req;
            last_dm_req = dmem_req;
            if (dmem_req.valid && dmem_rsp.ready) begin
                if (!exp_pending) begin
                    proto_errors++;
                    $display("%0t ns: data request where none was expected", $time);
                end else begin
                    check_store(dmem_req);
                end
                exp_pending = 1'b0;
            end
            if (if_req.valid && if_rsp.ready) begin
                if (exp_pending) begin
                    proto_errors++;
                    $display("%0t ns: expected data request is missing before fetch at %h",
                             $time, if_req.addr);
                end
                check_fetch(if_req.addr);
                if (ref_pc == PC_START + 64'(4 * (PROG_LEN - 1))) begin
                    done = 1'b1;
                end
                exp_req = ref_step(inst_at(ref_pc), next_pc);
                exp_pending = exp_req.valid;
                ref_pc = next_pc;
            end
        end
    end

    initial begin
        reset = 1'b1;
        done = 1'b0;
        cycles = 0;
        val_errors = 0;
        proto_errors = 0;
        lfsr = 16'd92;
        exp_pending = 1'b0;
        exp_req = '0;
        if_waiting = 1'b0;
        dm_waiting = 1'b0;
        last_if_req = '0;
        last_dm_req = '0;
        ref_pc = PC_START;
        for (int i = 0; i < 32; i++) begin
            ref_regs[i[4:0]] = '0;
        end
        for (int i = 0; i < MEM_DEPTH; i++) begin
            dmem[i[5:0]] = fill_word(64'(i * 8));
            ref_mem[i[5:0]] = fill_word(64'(i * 8));
        end
        n_inst = 0;
        put(enc_i(0, 0, 3, 1, rv_pkg::OPC_LOAD));
        put(enc_i(8, 0, 3, 2, rv_pkg::OPC_LOAD));
        put(enc_i(-5, 0, 0, 3, rv_pkg::OPC_OP_IMM));
        put(enc_r(0, 2, 1, 0, 4));
        put(enc_r(32, 2, 1, 0, 5));
        put(enc_r(0, 2, 1, 7, 6));
        put(enc_r(0, 2, 1, 6, 7));
        put(enc_r(0, 2, 1, 4, 8));
        put(enc_r(0, 0, 3, 2, 9));
        put(enc_r(0, 0, 3, 3, 10));
        put(enc_i(3, 3, 2, 11, rv_pkg::OPC_OP_IMM));
        put(enc_i(3, 3, 3, 12, rv_pkg::OPC_OP_IMM));
        put(enc_i(255, 1, 7, 13, rv_pkg::OPC_OP_IMM));
        put(enc_i(-256, 2, 6, 14, rv_pkg::OPC_OP_IMM));
        put(enc_i(1365, 1, 4, 15, rv_pkg::OPC_OP_IMM));
        put({20'hfedcb, 5'd16, rv_pkg::OPC_LUI});
        // every result goes out through sd
        for (int k = 0; k < 13; k++) begin
            put(enc_s(16 + 8 * k, 4 + k, 0));
        end
        put(enc_i(5, 1, 0, 0, rv_pkg::OPC_OP_IMM));
        put(enc_s(120, 0, 0));
        put(enc_i(16, 0, 3, 17, rv_pkg::OPC_LOAD));
        put(enc_s(128, 17, 0));
        // each branch condition both falls through and jumps
        put(enc_b(8, 2, 1, 0));
        put(enc_b(8, 1, 1, 0));
        put(enc_i(1, 0, 0, 20, rv_pkg::OPC_OP_IMM));
        put(enc_b(8, 1, 1, 1));
        put(enc_b(8, 3, 0, 4));
        put(enc_b(8, 0, 3, 4));
        put(enc_i(1, 0, 0, 21, rv_pkg::OPC_OP_IMM));
        put(enc_b(8, 0, 3, 5));
        put(enc_b(8, 3, 0, 5));
        put(enc_i(1, 0, 0, 22, rv_pkg::OPC_OP_IMM));
        put(enc_b(8, 2, 1, 1));
        put(enc_i(1, 0, 0, 23, rv_pkg::OPC_OP_IMM));
        put(enc_j(8, 18));
        put(enc_i(7, 0, 0, 24, rv_pkg::OPC_OP_IMM));
        // ecall decodes as a no-op
        put(32'h0000_0073);
        put(enc_s(136, 18, 0));
        put(enc_j(0, 0));

        repeat (5) @(posedge inst_selfdefine);
        #1 reset = 1'b0;
        wait (done || cycles >= TIMEOUT);
        if (!done) begin
            proto_errors++;
            $display("timeout after %0d cycles before the program reached its end", cycles);
        end
        $display("errors: %0d wrong values, %0d protocol", val_errors, proto_errors);
        if (val_errors + proto_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
rtl/rv_pkg.sv
rtl/fetch_unit.sv
rtl/decoder.sv
rtl/execute.sv
rtl/regfile.sv
rtl/mem_access.sv
rtl/cpu.sv
testbench/tb_cpu.sv

// ==== Makefile ====
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f sim.f --top-module tb_cpu -o Vtb_cpu

run: build
	./obj_dir/Vtb_cpu | tee sim.log
	grep -q "All tests passed" sim.log

lint:
	verilator --lint-only --timing -f sim.f --top-module tb_cpu

clean:
	rm -rf obj_dir sim.log
